// File: boot_status.sv
`timescale 1ns/10ps

module boot_status #(
  parameter int TICK_DIV       = 48000,
  parameter int PRESENCE_LIMIT = 48000000
) (
  input  logic clk,
  input  logic ns_rst,
  input  logic boot_req,
  input  logic sof_valid,
  output logic led,
  output logic boot
);

  localparam int TICK_W  = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
  localparam int TIMER_W = $clog2(PRESENCE_LIMIT + 2);

  logic [TICK_W-1:0]  tick_cnt;
  logic               tick;
  logic [7:0]         brightness;
  logic [7:0]         pwm_cnt;
  logic               count_down;
  logic [TIMER_W-1:0] presence_timer;
  logic               timeout;
  logic               boot_latch;

  //////////////////////////////////////////////////////////////////////
  // breathing led

  assign tick = (tick_cnt == TICK_W'(TICK_DIV - 1));
  assign led  = (brightness > pwm_cnt);

  always_ff @(posedge clk) begin
    if (ns_rst) begin
      tick_cnt   <= '0;
      pwm_cnt    <= '0;
      brightness <= '0;
      count_down <= 1'b0;
    end else begin
      pwm_cnt  <= pwm_cnt + 1'b1;
      tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
      if (tick) begin
        // ramp 0 to 255 and back
        if (count_down) begin
          if (brightness == 8'd0) begin
            count_down <= 1'b0;
          end else begin
            brightness <= brightness - 1'b1;
          end
        end else begin
          if (brightness == 8'd255) begin
            count_down <= 1'b1;
          end else begin
            brightness <= brightness + 1'b1;
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // host presence and boot

  assign boot = timeout | boot_latch;

  always_ff @(posedge clk) begin
    if (ns_rst) begin
      presence_timer <= '0;
      timeout        <= 1'b0;
      boot_latch     <= 1'b0;
    end else begin
      if (boot_req) begin
        boot_latch <= 1'b1;
      end
      if (sof_valid) begin
        presence_timer <= '0;
        timeout        <= 1'b0;
      end else if (presence_timer > TIMER_W'(PRESENCE_LIMIT)) begin
        timeout <= 1'b1;
      end else begin
        presence_timer <= presence_timer + 1'b1;
      end
    end
  end

endmodule

// File: bridge_decode.sv
`timescale 1ns/10ps

module bridge_decode (
  input  logic       clk,
  input  logic       ns_rst,
  input  logic       out_avail,
  output logic       out_get,
  input  logic [7:0] out_data,
  input  logic       full,
  output logic       boot_req,
  spi_cmd_if.decode  cmd
);

  localparam logic [2:0] HDR_LAST = 3'(bridge_pkg::HDR_BYTES - 1);

  typedef enum logic [2:0] {
    st_hdr_get,
    st_hdr_take,
    st_dispatch,
    st_pay_get,
    st_pay_take,
    st_pay_issue,
    st_read,
    st_release
  } state_e;

  state_e                        state;
  state_e                        state_nxt;
  logic [2:0]                    hdr_idx;
  bridge_pkg::cmd_op_e           op_q;
  logic [bridge_pkg::LEN_W-1:0]  write_cnt;
  logic [bridge_pkg::LEN_W-1:0]  read_cnt;
  logic [7:0]                    pay_byte;
  logic                          is_xfer;

  assign is_xfer = (op_q == bridge_pkg::spi_xfer);

  //////////////////////////////////////////////////////////////////////
  // header capture and counters

  always_ff @(posedge clk) begin
    if (ns_rst) begin
      state     <= st_hdr_get;
      hdr_idx   <= '0;
      op_q      <= bridge_pkg::nop;
      write_cnt <= '0;
      read_cnt  <= '0;
    end else begin
      state <= state_nxt;
      case (state)
        st_hdr_take: begin
          case (hdr_idx)
            bridge_pkg::HDR_OPCODE:  op_q <= bridge_pkg::cmd_op_e'(out_data);
            bridge_pkg::HDR_WLEN_LO: write_cnt[7:0] <= out_data;
            bridge_pkg::HDR_WLEN_HI: write_cnt[bridge_pkg::LEN_W-1:8] <= out_data;
            bridge_pkg::HDR_RLEN_LO: read_cnt[7:0] <= out_data;
            bridge_pkg::HDR_RLEN_HI: read_cnt[bridge_pkg::LEN_W-1:8] <= out_data;
            default: ;
          endcase
          if (hdr_idx == HDR_LAST) begin
            hdr_idx <= '0;
          end else begin
            hdr_idx <= hdr_idx + 1'b1;
          end
        end
        st_pay_take: write_cnt <= write_cnt - 1'b1;
        st_read: begin
          if (cmd.cmd_valid) begin
            read_cnt <= read_cnt - 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  // payload byte waits here until execute is idle
  always_ff @(posedge clk) begin
    if (state == st_pay_take) begin
      pay_byte <= out_data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // sequencing

  always_comb begin
    state_nxt     = state;
    out_get       = 1'b0;
    boot_req      = 1'b0;
    cmd.cmd_valid = 1'b0;
    cmd.cmd_op    = spi_pkg::shift_write;
    cmd.cmd_byte  = '0;
    cmd.cmd_last  = 1'b0;
    case (state)
      st_hdr_get: begin
        if (out_avail) begin
          out_get   = 1'b1;
          state_nxt = st_hdr_take;
        end
      end
      st_hdr_take: state_nxt = (hdr_idx == HDR_LAST) ? st_dispatch : st_hdr_get;
      st_dispatch: begin
        boot_req = (op_q == bridge_pkg::boot);
        // zero length transfer leaves CS alone
        if (is_xfer && write_cnt == '0) begin
          state_nxt = (read_cnt != '0) ? st_read : st_hdr_get;
        end else if (write_cnt != '0) begin
          state_nxt = st_pay_get;
        end else begin
          state_nxt = st_hdr_get;
        end
      end
      st_pay_get: begin
        if (out_avail) begin
          out_get   = 1'b1;
          state_nxt = st_pay_take;
        end
      end
      st_pay_take: begin
        // other opcodes just drain the payload
        if (is_xfer) begin
          state_nxt = st_pay_issue;
        end else if (write_cnt == bridge_pkg::LEN_W'(1)) begin
          state_nxt = st_hdr_get;
        end else begin
          state_nxt = st_pay_get;
        end
      end
      st_pay_issue: begin
        if (!cmd.busy) begin
          cmd.cmd_valid = 1'b1;
          cmd.cmd_byte  = pay_byte;
          if (write_cnt != '0) begin
            state_nxt = st_pay_get;
          end else if (read_cnt != '0) begin
            state_nxt = st_read;
          end else begin
            state_nxt = st_release;
          end
        end
      end
      st_read: begin
        // only with room in the return buffer
        if (!cmd.busy && !full) begin
          cmd.cmd_valid = 1'b1;
          cmd.cmd_op    = spi_pkg::shift_read;
          cmd.cmd_last  = (read_cnt == bridge_pkg::LEN_W'(1));
          if (read_cnt == bridge_pkg::LEN_W'(1)) begin
            state_nxt = st_release;
          end
        end
      end
      st_release: begin
        if (!cmd.busy) begin
          cmd.cmd_valid = 1'b1;
          cmd.cmd_op    = spi_pkg::cs_release;
          state_nxt     = st_hdr_get;
        end
      end
      default: state_nxt = st_hdr_get;
    endcase
  end

  // each fetch is get then sample
  a_get_spaced: assert property (@(posedge clk) disable iff (ns_rst) out_get |=> !out_get);

endmodule

// File: bridge_pkg.sv
package bridge_pkg;

  //////////////////////////////////////////////////////////////////////
  // host command set

  // opcode carried in the first header byte
  typedef enum logic [7:0] {
    nop      = 8'h00,
    boot     = 8'h01,
    spi_xfer = 8'h02
  } cmd_op_e;

  // write_len and read_len width
  localparam int LEN_W = 16;

  //////////////////////////////////////////////////////////////////////
  // command header layout

  // opcode, write_len lo/hi, read_len lo/hi
  localparam int HDR_BYTES = 5;

  // byte positions inside the header
  localparam logic [2:0] HDR_OPCODE  = 3'd0;
  localparam logic [2:0] HDR_WLEN_LO = 3'd1;
  localparam logic [2:0] HDR_WLEN_HI = 3'd2;
  localparam logic [2:0] HDR_RLEN_LO = 3'd3;
  localparam logic [2:0] HDR_RLEN_HI = 3'd4;

endpackage

// File: bridge_result.sv
`timescale 1ns/10ps

module bridge_result (
  input  logic       clk,
  input  logic       ns_rst,
  input  logic       rd_valid,
  input  logic [7:0] rd_byte,
  input  logic       rd_last,
  output logic       full,
  input  logic       in_free,
  output logic       in_put,
  output logic [7:0] in_data,
  output logic       in_done
);

  logic       hold_valid;
  logic [7:0] hold_data;
  logic       hold_last;

  // a byte arriving this cycle already counts as occupying the slot
  assign full    = hold_valid | rd_valid;
  assign in_put  = hold_valid & in_free;
  assign in_data = hold_data;

  always_ff @(posedge clk) begin
    if (ns_rst) begin
      hold_valid <= 1'b0;
      in_done    <= 1'b0;
    end else begin
      in_done <= in_put & hold_last;
      if (rd_valid) begin
        hold_valid <= 1'b1;
      end else if (in_put) begin
        hold_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_valid) begin
      hold_data <= rd_byte;
      hold_last <= rd_last;
    end
  end

  // decode waits on full before each read
  a_no_overrun: assert property (
    @(posedge clk) disable iff (ns_rst) rd_valid |-> !hold_valid);

endmodule

// File: flash_bootloader.sv
`timescale 1ns/10ps

module flash_bootloader #(
  parameter int SPI_DIV        = 2,
  parameter int TICK_DIV       = 48000,
  parameter int PRESENCE_LIMIT = 48000000
) (
  input  logic       clk,
  input  logic       ns_rst,
  // out endpoint, host to core
  input  logic       out_avail,
  output logic       out_get,
  input  logic [7:0] out_data,
  // in endpoint, core to host
  input  logic       in_free,
  output logic       in_put,
  output logic [7:0] in_data,
  output logic       in_done,
  input  logic       sof_valid,
  // flash
  output logic       spi_cs,
  output logic       spi_sck,
  output logic       spi_mosi,
  input  logic       spi_miso,
  output logic       led,
  output logic       boot
);

  logic       full;
  logic       rd_valid;
  logic [7:0] rd_byte;
  logic       rd_last;
  logic       boot_req;

  spi_cmd_if spi_cmd0 ();

  bridge_decode decode0 (
    .clk       (clk),
    .ns_rst    (ns_rst),
    .out_avail (out_avail),
    .out_get   (out_get),
    .out_data  (out_data),
    .full      (full),
    .boot_req  (boot_req),
    .cmd       (spi_cmd0.decode)
  );

  spi_execute #(
    .SPI_DIV (SPI_DIV)
  ) execute0 (
    .clk      (clk),
    .ns_rst   (ns_rst),
    .cmd      (spi_cmd0.execute),
    .rd_valid (rd_valid),
    .rd_byte  (rd_byte),
    .rd_last  (rd_last),
    .spi_cs   (spi_cs),
    .spi_sck  (spi_sck),
    .spi_mosi (spi_mosi),
    .spi_miso (spi_miso)
  );

  bridge_result result0 (
    .clk      (clk),
    .ns_rst   (ns_rst),
    .rd_valid (rd_valid),
    .rd_byte  (rd_byte),
    .rd_last  (rd_last),
    .full     (full),
    .in_free  (in_free),
    .in_put   (in_put),
    .in_data  (in_data),
    .in_done  (in_done)
  );

  boot_status #(
    .TICK_DIV       (TICK_DIV),
    .PRESENCE_LIMIT (PRESENCE_LIMIT)
  ) status0 (
    .clk       (clk),
    .ns_rst    (ns_rst),
    .boot_req  (boot_req),
    .sof_valid (sof_valid),
    .led       (led),
    .boot      (boot)
  );

endmodule

// File: spi_cmd_if.sv
`timescale 1ns/10ps

interface spi_cmd_if;

  // one strobe per byte operation
  logic                       cmd_valid;
  spi_pkg::spi_op_e           cmd_op;
  logic [spi_pkg::BYTE_W-1:0] cmd_byte;
  // marks the final read of a transfer
  logic                       cmd_last;
  // high from the cycle after cmd_valid until the operation ends
  logic                       busy;

  modport decode (
    output cmd_valid,
    output cmd_op,
    output cmd_byte,
    output cmd_last,
    input  busy
  );

  modport execute (
    input  cmd_valid,
    input  cmd_op,
    input  cmd_byte,
    input  cmd_last,
    output busy
  );

endinterface

// File: spi_execute.sv
`timescale 1ns/10ps

module spi_execute #(
  parameter int SPI_DIV = 2
) (
  input  logic       clk,
  input  logic       ns_rst,
  spi_cmd_if.execute cmd,
  output logic       rd_valid,
  output logic [7:0] rd_byte,
  output logic       rd_last,
  output logic       spi_cs,
  output logic       spi_sck,
  output logic       spi_mosi,
  input  logic       spi_miso
);

  localparam int DIV_W = (SPI_DIV > 1) ? $clog2(SPI_DIV) : 1;
  localparam int BIT_W = $clog2(spi_pkg::BYTE_W);

  typedef enum logic [1:0] {
    ex_idle,
    ex_shift,
    ex_release
  } ex_state_e;

  ex_state_e                  state;
  logic [DIV_W-1:0]           div_cnt;
  logic [BIT_W-1:0]           bit_cnt;
  logic [spi_pkg::BYTE_W-1:0] shift_reg;
  spi_pkg::spi_op_e           op_q;
  logic                       last_q;
  logic                       half_done;

  assign half_done = (div_cnt == DIV_W'(SPI_DIV - 1));
  assign rd_byte   = shift_reg;
  assign rd_last   = last_q;

  //////////////////////////////////////////////////////////////////////
  // mode 0 bit timing, msb first

  always_ff @(posedge clk) begin
    if (ns_rst) begin
      state    <= ex_idle;
      cmd.busy <= 1'b0;
      rd_valid <= 1'b0;
      spi_cs   <= 1'b1;
      spi_sck  <= 1'b0;
      spi_mosi <= 1'b0;
      div_cnt  <= '0;
      bit_cnt  <= '0;
    end else begin
      rd_valid <= 1'b0;
      case (state)
        ex_idle: begin
          if (cmd.cmd_valid) begin
            cmd.busy <= 1'b1;
            div_cnt  <= '0;
            if (cmd.cmd_op == spi_pkg::cs_release) begin
              spi_cs <= 1'b1;
              state  <= ex_release;
            end else begin
              // first bit gets a full half period of setup
              spi_cs   <= 1'b0;
              bit_cnt  <= '0;
              spi_mosi <= (cmd.cmd_op == spi_pkg::shift_write) ?
                          cmd.cmd_byte[spi_pkg::BYTE_W-1] : 1'b0;
              state    <= ex_shift;
            end
          end
        end
        ex_shift: begin
          if (half_done) begin
            div_cnt <= '0;
            spi_sck <= ~spi_sck;
            if (spi_sck) begin
              // falling edge
              if (bit_cnt == BIT_W'(spi_pkg::BYTE_W - 1)) begin
                cmd.busy <= 1'b0;
                rd_valid <= (op_q == spi_pkg::shift_read);
                spi_mosi <= 1'b0;
                state    <= ex_idle;
              end else begin
                bit_cnt  <= bit_cnt + 1'b1;
                spi_mosi <= (op_q == spi_pkg::shift_write) ?
                            shift_reg[spi_pkg::BYTE_W-1] : 1'b0;
              end
            end
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        ex_release: begin
          cmd.busy <= 1'b0;
          state    <= ex_idle;
        end
        default: state <= ex_idle;
      endcase
    end
  end

  // shared shifter, tx bits leave the top as miso enters the bottom
  always_ff @(posedge clk) begin
    if (state == ex_idle && cmd.cmd_valid) begin
      op_q      <= cmd.cmd_op;
      last_q    <= cmd.cmd_last;
      shift_reg <= (cmd.cmd_op == spi_pkg::shift_write) ? cmd.cmd_byte : '0;
    end else if (state == ex_shift && half_done && !spi_sck) begin
      shift_reg <= {shift_reg[spi_pkg::BYTE_W-2:0], spi_miso};
    end
  end

  // decode must hold off until the previous byte is done
  a_no_cmd_busy: assert property (
    @(posedge clk) disable iff (ns_rst) cmd.cmd_valid |-> !cmd.busy);

endmodule

// File: spi_pkg.sv
package spi_pkg;

  //////////////////////////////////////////////////////////////////////
  // flash side byte operations

  // one entry per byte moved on the bus, plus chip select release
  typedef enum logic [1:0] {
    shift_write = 2'd0,
    shift_read  = 2'd1,
    cs_release  = 2'd2
  } spi_op_e;

  // bits per SPI byte
  localparam int BYTE_W = 8;

endpackage

// File: tb_flash_bootloader.sv
`timescale 1ns/10ps

module tb_flash_bootloader;

  localparam int SPI_DIV        = 2;
  localparam int TICK_DIV       = 4;
  localparam int PRESENCE_LIMIT = 2000;

  logic       clk;
  logic       ns_rst;
  logic       out_avail;
  logic       out_get;
  logic [7:0] out_data;
  logic       in_free;
  logic       in_put;
  logic [7:0] in_data;
  logic       in_done;
  logic       sof_valid;
  logic       spi_cs;
  logic       spi_sck;
  logic       spi_mosi;
  logic       spi_miso;
  logic       led;
  logic       boot;

  integer     seed;
  int         check_errors   = 0;
  int         timeout_errors = 0;
  logic [7:0] pay_q[$];

  // host endpoint model state
  logic [7:0] host_q[$];
  logic       get_pending    = 1'b0;
  logic [7:0] in_q[$];
  logic       prev_put       = 1'b0;
  int         done_cnt       = 0;
  int         done_puts      = 0;
  logic       done_after_put = 1'b0;
  logic       free_toggle    = 1'b0;
  int         free_phase     = 0;

  // flash model state
  logic [7:0] mosi_q[$];
  logic [7:0] mosi_sr        = 8'h00;
  int         flash_bits     = 0;
  int         flash_wr_bytes = 0;
  int         cs_fall_cnt    = 0;
  int         cs_rise_cnt    = 0;

  flash_bootloader #(
    .SPI_DIV        (SPI_DIV),
    .TICK_DIV       (TICK_DIV),
    .PRESENCE_LIMIT (PRESENCE_LIMIT)
  ) dut0 (
    .clk       (clk),
    .ns_rst    (ns_rst),
    .out_avail (out_avail),
    .out_get   (out_get),
    .out_data  (out_data),
    .in_free   (in_free),
    .in_put    (in_put),
    .in_data   (in_data),
    .in_done   (in_done),
    .sof_valid (sof_valid),
    .spi_cs    (spi_cs),
    .spi_sck   (spi_sck),
    .spi_mosi  (spi_mosi),
    .spi_miso  (spi_miso),
    .led       (led),
    .boot      (boot)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic flag_error(input string msg);
    $display("FAIL %0t: %s", $time, msg);
    check_errors++;
  endtask

  //////////////////////////////////////////////////////////////////////
  // host side of the endpoints

  // a get seen before the edge gets its byte on the next falling edge
  always begin
    @(negedge clk);
    if (get_pending) begin
      out_data = host_q.pop_front();
    end
    out_avail = (host_q.size() != 0);
    #1;
    get_pending = out_get && !ns_rst;
  end

  // in_free low for 60 of every 100 cycles while toggling
  always @(negedge clk) begin
    free_phase = (free_phase + 1) % 100;
    in_free    = !free_toggle || (free_phase >= 60);
  end

  always @(posedge clk) begin
    if (in_done) begin
      done_cnt++;
      done_puts      = in_q.size();
      done_after_put = prev_put;
    end
    if (in_put) begin
      in_q.push_back(in_data);
      if (!in_free) begin
        flag_error("in_put while in_free is low");
      end
    end
    prev_put = in_put;
  end

  //////////////////////////////////////////////////////////////////////
  // flash model in mode 0

  task automatic drive_miso;
    int         byte_idx;
    int         bit_idx;
    logic [7:0] rd;
    byte_idx = flash_bits / 8;
    bit_idx  = flash_bits % 8;
    if (byte_idx >= flash_wr_bytes) begin
      rd       = 8'h3C + 8'(byte_idx - flash_wr_bytes);
      spi_miso = rd[7 - bit_idx];
    end else begin
      spi_miso = 1'b0;
    end
  endtask

  always @(negedge spi_cs) begin
    cs_fall_cnt++;
    flash_bits = 0;
    drive_miso();
  end

  always @(posedge spi_cs) begin
    cs_rise_cnt++;
  end

  always @(posedge spi_sck) begin
    if (!spi_cs) begin
      mosi_sr = {mosi_sr[6:0], spi_mosi};
      flash_bits++;
      if (flash_bits % 8 == 0) begin
        mosi_q.push_back(mosi_sr);
      end
    end
  end

  always @(negedge spi_sck) begin
    if (!spi_cs) begin
      drive_miso();
    end
  end

  //////////////////////////////////////////////////////////////////////
  // helpers

  task apply_reset;
    @(negedge clk);
    ns_rst = 1'b1;
    repeat (8) @(negedge clk);
    ns_rst = 1'b0;
  endtask

  task make_payload(input int count);
    int i;
    pay_q.delete();
    for (i = 0; i < count; i++) begin
      pay_q.push_back(8'($random(seed)));
    end
  endtask

  // header then the first wlen bytes of pay_q
  task push_cmd(input logic [7:0] op, input logic [bridge_pkg::LEN_W-1:0] wlen,
                input logic [bridge_pkg::LEN_W-1:0] rlen);
    int i;
    host_q.push_back(op);
    host_q.push_back(wlen[7:0]);
    host_q.push_back(wlen[15:8]);
    host_q.push_back(rlen[7:0]);
    host_q.push_back(rlen[15:8]);
    for (i = 0; i < wlen; i++) begin
      host_q.push_back(pay_q[i]);
    end
  endtask

  task wait_cs_rise(input int start, input int limit);
    int n;
    n = 0;
    while (cs_rise_cnt == start && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (cs_rise_cnt == start) begin
      $display("timeout at %0t: chip select never went high again", $time);
      timeout_errors++;
    end
  endtask

  task wait_done(input int start, input int limit);
    int n;
    n = 0;
    while (done_cnt == start && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (done_cnt == start) begin
      $display("timeout at %0t: in_done never pulsed", $time);
      timeout_errors++;
    end
  endtask

  task wait_host_drained(input int limit);
    int n;
    n = 0;
    while ((host_q.size() != 0 || out_avail) && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (host_q.size() != 0) begin
      $display("timeout at %0t: host queue was not consumed", $time);
      timeout_errors++;
    end
  endtask

  task wait_boot(input int limit);
    int n;
    n = 0;
    while (boot !== 1'b1 && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (boot !== 1'b1) begin
      $display("timeout at %0t: boot never went high", $time);
      timeout_errors++;
    end
  endtask

  task check_mosi(input int count);
    int i;
    if (mosi_q.size() < count) begin
      flag_error($sformatf("only %0d mosi bytes, expected %0d", mosi_q.size(), count));
    end else begin
      for (i = 0; i < count; i++) begin
        if (mosi_q[i] !== pay_q[i]) begin
          flag_error($sformatf("mosi byte %0d is %h, expected %h", i, mosi_q[i], pay_q[i]));
        end
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests

  task run_reset_state;
    apply_reset();
    if (spi_cs !== 1'b1) flag_error("spi_cs not high after reset");
    if (boot !== 1'b0) flag_error("boot not low after reset");
    if (out_get !== 1'b0) flag_error("out_get not low after reset");
    if (in_put !== 1'b0) flag_error("in_put not low after reset");
  endtask

  task run_write_only;
    int rise0;
    int puts0;
    make_payload(4);
    mosi_q.delete();
    flash_wr_bytes = 4;
    rise0 = cs_rise_cnt;
    puts0 = in_q.size();
    push_cmd(bridge_pkg::spi_xfer, 4, 0);
    wait_cs_rise(rise0, 3000);
    check_mosi(4);
    if (spi_cs !== 1'b1) flag_error("spi_cs low after write transfer");
    if (in_q.size() != puts0) flag_error("in_put seen during write-only transfer");
    if (host_q.size() != 0) flag_error("host queue not empty after write transfer");
  endtask

  task run_write_read;
    int done0;
    int rise0;
    int i;
    make_payload(2);
    mosi_q.delete();
    in_q.delete();
    flash_wr_bytes = 2;
    done0 = done_cnt;
    rise0 = cs_rise_cnt;
    free_toggle = 1'b1;
    push_cmd(bridge_pkg::spi_xfer, 2, 5);
    wait_done(done0, 4000);
    wait_cs_rise(rise0, 4000);
    free_toggle = 1'b0;
    check_mosi(2);
    if (in_q.size() != 5) begin
      flag_error($sformatf("%0d bytes returned, expected 5", in_q.size()));
    end else begin
      for (i = 0; i < 5; i++) begin
        if (in_q[i] !== 8'h3C + 8'(i)) begin
          flag_error($sformatf("read byte %0d is %h, expected %h", i, in_q[i], 8'h3C + 8'(i)));
        end
      end
    end
    if (done_cnt != done0 + 1 || done_puts != 5 || !done_after_put) begin
      flag_error("in_done did not follow the fifth byte");
    end
  endtask

  task run_drop_payload;
    int falls0;
    falls0 = cs_fall_cnt;
    make_payload(3);
    push_cmd(bridge_pkg::nop, 3, 0);
    push_cmd(8'h7E, 3, 0);
    wait_host_drained(1000);
    // let the last byte be taken and decode settle
    repeat (10) @(negedge clk);
    if (cs_fall_cnt != falls0) flag_error("chip select fell for nop or unknown opcode");
    run_write_only();
  endtask

  task run_boot_sources;
    int   n;
    logic early_boot;
    early_boot = 1'b0;
    // fresh presence timer so only the command can raise boot here
    apply_reset();
    push_cmd(bridge_pkg::boot, 0, 0);
    wait_boot(200);
    apply_reset();
    for (n = 0; n < 5000; n++) begin
      sof_valid = (n % 500 == 499);
      @(negedge clk);
      if (boot !== 1'b0) early_boot = 1'b1;
    end
    sof_valid = 1'b0;
    if (early_boot) flag_error("boot went high while sof_valid was pulsing");
    wait_boot(PRESENCE_LIMIT + 100);
  endtask

  task run_led;
    int   n;
    logic seen_hi;
    logic seen_lo;
    seen_hi = 1'b0;
    seen_lo = 1'b0;
    for (n = 0; n < 3000; n++) begin
      @(negedge clk);
      if (led === 1'b1) seen_hi = 1'b1;
      if (led === 1'b0) seen_lo = 1'b1;
    end
    if (!seen_hi || !seen_lo) flag_error("led did not toggle over the window");
  endtask

  initial begin
    seed      = 32'h0080dffd;
    ns_rst    = 1'b1;
    out_avail = 1'b0;
    out_data  = 8'h00;
    in_free   = 1'b1;
    sof_valid = 1'b0;
    spi_miso  = 1'b0;

    run_reset_state();
    run_write_only();
    run_write_read();
    run_drop_payload();
    run_boot_sources();
    run_led();

    $display("check errors: %0d, timeouts: %0d", check_errors, timeout_errors);
    if (check_errors == 0 && timeout_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
bridge_pkg.sv
spi_pkg.sv
spi_cmd_if.sv
bridge_decode.sv
spi_execute.sv
bridge_result.sv
boot_status.sv
flash_bootloader.sv
tb_flash_bootloader.sv
